//--- Makefile
# Verilator build and run of the interrupt controller testbench

TOP := tbInterruptController
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f sim.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

# Pass only when the log holds the pass line
run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- logic/commandDecoder.sv
//####################
// Host write decoder
// Turns ICW/OCW bytes into configuration and EOI events
//####################
`default_nettype none

`include "pic_defines.svh"

module commandDecoder (
    input  wire logic               clk,
    input  wire logic               resetIRR,
    input  wire picPkg::hostWrite_t hostWr,   // Command byte from the host
    output picPkg::picConfig_t      cfg,      // Live configuration for all stages
    output picPkg::eoiEvent_t       eoiEvent  // One-cycle EOI pulse
);

    picPkg::commandWord_u cmdWord;  // Same byte seen as ICW1 and as OCW
    logic                 awaitIcw2; // Set by ICW1 until the a0 = 1 write of ICW2

    logic isIcw1;
    logic isIcw2;
    logic isOcw1;
    logic isOcw2;
    logic isOcw3;

    assign cmdWord = hostWr.data;

    // Write classification
    always_comb begin
        isIcw1 = hostWr.wr && !hostWr.a0 && cmdWord.icw1.initFlag;
        isIcw2 = hostWr.wr && hostWr.a0 && awaitIcw2;
        // OCWs only count once initialization is complete
        isOcw1 = hostWr.wr && hostWr.a0 && cfg.initDone;
        isOcw2 = hostWr.wr && !hostWr.a0 && cfg.initDone
                 && (cmdWord.ocw.selector == 2'b00);
        isOcw3 = hostWr.wr && !hostWr.a0 && cfg.initDone
                 && (cmdWord.ocw.selector == 2'b01);
    end

    always_ff @(posedge clk) begin
        if (resetIRR) begin
            cfg       <= '0;
            awaitIcw2 <= 1'b0;
            eoiEvent  <= '0;
        end else begin
            eoiEvent <= '0; // Pulse lasts one cycle

            if (isIcw1) begin
                cfg.levelMode <= cmdWord.icw1.ltim;
                cfg.mask      <= '0;   // ICW1 clears the IMR
                cfg.readIsr   <= 1'b0; // Reads fall back to IRR
                cfg.initDone  <= 1'b0;
                awaitIcw2     <= 1'b1;
            end else if (isIcw2) begin
                cfg.vectorBase <= hostWr.data[7:`PIC_LEVEL_BITS];
                cfg.initDone   <= 1'b1;
                awaitIcw2      <= 1'b0;
            end else if (isOcw1) begin
                cfg.mask <= hostWr.data;
            end else if (isOcw2) begin
                // Rotate bit ignored since rotation is not supported
                if (cmdWord.ocw.ctrl[0]) begin
                    eoiEvent.strobe   <= 1'b1;
                    eoiEvent.specific <= cmdWord.ocw.ctrl[1];
                    eoiEvent.level    <= cmdWord.ocw.low;
                end
            end else if (isOcw3) begin
                if (cmdWord.ocw.low[1]) // RR enable
                    cfg.readIsr <= cmdWord.ocw.low[0];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/interruptController.sv
//####################
// Interrupt controller top level
// Decoder, IRR, resolver and output stage wired together
//####################
`default_nettype none

`include "pic_defines.svh"

module interruptController (
    input  wire logic                  clk,
    input  wire logic                  resetIRR,
    input  wire picPkg::hostWrite_t    hostWr,       // Command writes
    input  wire logic [`PIC_LINES-1:0] requestLines, // IR0..IR7
    input  wire logic                  inta,
    input  wire logic                  rd,
    input  wire logic                  readA0,
    output wire logic                  intr,
    output wire logic                  vectorValid,
    output wire logic [7:0]            vector,
    output wire logic                  readValid,
    output wire logic [`PIC_LINES-1:0] readData
);

    picPkg::picConfig_t    cfg;
    picPkg::eoiEvent_t     eoiEvent;
    picPkg::ackEvent_t     ackEvent;     // Resolver back to IRR and output
    logic [`PIC_LINES-1:0] irr;
    logic [`PIC_LINES-1:0] isr;
    logic                  pendingValid;

    commandDecoder decoder (
        .clk(clk), .resetIRR(resetIRR), .hostWr(hostWr),
        .cfg(cfg), .eoiEvent(eoiEvent)
    );

    interruptRequestRegister requestReg (
        .clk(clk), .resetIRR(resetIRR), .requestLines(requestLines),
        .cfg(cfg), .ackEvent(ackEvent), .irr(irr)
    );

    priorityResolver resolver (
        .clk(clk), .resetIRR(resetIRR), .irr(irr), .cfg(cfg), .inta(inta),
        .eoiEvent(eoiEvent), .isr(isr), .pendingValid(pendingValid),
        .ackEvent(ackEvent)
    );

    vectorOutput outStage (
        .clk(clk), .resetIRR(resetIRR), .cfg(cfg), .pendingValid(pendingValid),
        .ackEvent(ackEvent), .irr(irr), .isr(isr), .rd(rd), .readA0(readA0),
        .intr(intr), .vectorValid(vectorValid), .vector(vector),
        .readValid(readValid), .readData(readData)
    );

endmodule

`default_nettype wire

//--- logic/interruptRequestRegister.sv
//####################
// Interrupt request register
// Edge capture or level follow of masked IR lines
//####################
`default_nettype none

`include "pic_defines.svh"

module interruptRequestRegister (
    input  wire logic                  clk,
    input  wire logic                  resetIRR,
    input  wire logic [`PIC_LINES-1:0] requestLines, // IR0..IR7 from devices
    input  wire picPkg::picConfig_t    cfg,
    input  wire picPkg::ackEvent_t     ackEvent,     // Clears the serviced bit
    output logic      [`PIC_LINES-1:0] irr
);

    logic [`PIC_LINES-1:0] prevLines;   // Raw lines one cycle back
    logic [`PIC_LINES-1:0] irrStore;
    logic [`PIC_LINES-1:0] maskedReq;
    logic [`PIC_LINES-1:0] risingEdge;
    logic [`PIC_LINES-1:0] ackClear;

    always_comb begin
        maskedReq = requestLines & ~cfg.mask;
        // Raw history, so unmasking a held line is not an edge
        risingEdge = requestLines & ~prevLines & ~cfg.mask;

        ackClear = '0;
        if (ackEvent.strobe && !ackEvent.spurious)
            ackClear = `PIC_LINES'(1) << ackEvent.level;
    end

    always_ff @(posedge clk) begin
        if (resetIRR) begin
            prevLines <= '0;
            irrStore  <= '0;
        end else begin
            prevLines <= requestLines;
            if (cfg.levelMode)
                irrStore <= maskedReq & ~ackClear; // Dips for one cycle on ack
            else
                // New edge wins over a same-cycle ack of that line
                irrStore <= ((irrStore & ~ackClear) | risingEdge) & ~cfg.mask;
        end
    end

    // Mask also hides stored bits immediately
    assign irr = irrStore & ~cfg.mask;

endmodule

`default_nettype wire

//--- logic/picPkg.sv
//####################
// Shared types for the interrupt controller
// Referenced by scoped name from every stage
//####################
`default_nettype none

`include "pic_defines.svh"

package picPkg;

    // ICW1 view of a byte written at a0 = 0
    typedef struct packed {
        logic [2:0] unused;   // Bits 7..5, vector address bits of the MCS-80 mode
        logic       initFlag; // Bit 4 marks an ICW1
        logic       ltim;     // 1 selects level triggering
        logic [2:0] ignored;  // IC4, SNGL, ADI are not supported
    } icw1_t;

    // OCW2/OCW3 view of the same byte
    typedef struct packed {
        logic [2:0] ctrl;     // OCW2 rotate, specific, eoi
        logic [1:0] selector; // 00 OCW2, 01 OCW3
        logic [2:0] low;      // OCW2 level, OCW3 {unused, rr, ris}
    } ocw_t;

    // One address-0 byte, decoded both ways
    typedef union packed {
        icw1_t icw1;
        ocw_t  ocw;
    } commandWord_u;

    typedef struct packed {
        logic       wr;   // Single-cycle write strobe
        logic       a0;   // Address bit
        logic [7:0] data;
    } hostWrite_t;

    typedef struct packed {
        logic                                 levelMode;  // From ICW1 ltim
        logic [7:`PIC_LEVEL_BITS]             vectorBase; // ICW2 bits 7..3
        logic [`PIC_LINES-1:0]                mask;       // OCW1, 1 blocks the line
        logic                                 readIsr;    // OCW3 read select
        logic                                 initDone;   // Set by ICW2
    } picConfig_t;

    typedef struct packed {
        logic                       strobe;
        logic                       specific; // 0 clears highest isr bit
        logic [`PIC_LEVEL_BITS-1:0] level;
    } eoiEvent_t;

    typedef struct packed {
        logic                       strobe;
        logic                       spurious; // Nothing was pending
        logic [`PIC_LEVEL_BITS-1:0] level;
    } ackEvent_t;

endpackage

`default_nettype wire

//--- logic/pic_defines.svh
//####################
// Sizing constants for the interrupt controller
// Include wherever line vectors or level numbers are declared
//####################
`ifndef PIC_DEFINES_SVH
`define PIC_DEFINES_SVH

// Number of interrupt request lines IR0..IR7
`define PIC_LINES 8

// Width of a level number, log2 of the line count
`define PIC_LEVEL_BITS 3

// Level reported when inta finds nothing pending
`define PIC_SPURIOUS_LEVEL 7

`endif

//--- logic/priorityResolver.sv
//####################
// Fixed-priority resolver and in-service register
// IR0 highest, handles inta and EOI commands
//####################
`default_nettype none

`include "pic_defines.svh"

module priorityResolver (
    input  wire logic                  clk,
    input  wire logic                  resetIRR,
    input  wire logic [`PIC_LINES-1:0] irr,
    input  wire picPkg::picConfig_t    cfg,
    input  wire logic                  inta,        // One-cycle acknowledge
    input  wire picPkg::eoiEvent_t     eoiEvent,
    output logic      [`PIC_LINES-1:0] isr,
    output logic                       pendingValid, // Combinational
    output picPkg::ackEvent_t          ackEvent
);

    logic                       found;
    logic                       blocked;
    logic [`PIC_LEVEL_BITS-1:0] pendingLevel;
    logic [`PIC_LEVEL_BITS-1:0] topIsrLevel;  // Highest-priority in-service
    logic [`PIC_LINES-1:0]      eoiClear;
    logic [`PIC_LINES-1:0]      ackSet;

    // Scan from IR0, an isr bit blocks itself and everything below
    always_comb begin
        found        = 1'b0;
        blocked      = 1'b0;
        pendingLevel = '0;
        for (int i = 0; i < `PIC_LINES; i++) begin
            if (isr[i]) begin
                blocked = 1'b1;
            end else if (!blocked && !found && irr[i]) begin
                found        = 1'b1;
                pendingLevel = `PIC_LEVEL_BITS'(i);
            end
        end
    end

    assign pendingValid = found && cfg.initDone;

    // Lowest index set in isr, scanned downwards so IR0 lands last
    always_comb begin
        topIsrLevel = '0;
        for (int i = `PIC_LINES - 1; i >= 0; i--) begin
            if (isr[i])
                topIsrLevel = `PIC_LEVEL_BITS'(i);
        end
    end

    always_comb begin
        eoiClear = '0;
        if (eoiEvent.strobe)
            eoiClear = eoiEvent.specific ? (`PIC_LINES'(1) << eoiEvent.level)
                                         : (`PIC_LINES'(1) << topIsrLevel);
        ackSet = (inta && pendingValid) ? (`PIC_LINES'(1) << pendingLevel) : '0;
    end

    always_ff @(posedge clk) begin
        if (resetIRR) begin
            isr      <= '0;
            ackEvent <= '0;
        end else begin
            isr      <= (isr & ~eoiClear) | ackSet;
            ackEvent <= '0;
            if (inta) begin
                ackEvent.strobe <= 1'b1;
                if (pendingValid) begin
                    ackEvent.level <= pendingLevel;
                end else begin
                    ackEvent.spurious <= 1'b1; // Request vanished, report IR7
                    ackEvent.level    <= `PIC_LEVEL_BITS'(`PIC_SPURIOUS_LEVEL);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/vectorOutput.sv
//####################
// Output stage: intr level, inta vector and readback
//####################
`default_nettype none

`include "pic_defines.svh"

module vectorOutput (
    input  wire logic                  clk,
    input  wire logic                  resetIRR,
    input  wire picPkg::picConfig_t    cfg,
    input  wire logic                  pendingValid,
    input  wire picPkg::ackEvent_t     ackEvent,
    input  wire logic [`PIC_LINES-1:0] irr,
    input  wire logic [`PIC_LINES-1:0] isr,
    input  wire logic                  rd,       // One-cycle read strobe
    input  wire logic                  readA0,   // 1 reads the mask
    output logic                       intr,
    output logic                       vectorValid,
    output logic      [7:0]            vector,
    output logic                       readValid,
    output logic      [`PIC_LINES-1:0] readData
);

    logic [`PIC_LINES-1:0] readSel;

    // Readback source: IMR on a0, else IRR or ISR per OCW3
    always_comb begin
        if (readA0)
            readSel = cfg.mask;
        else if (cfg.readIsr)
            readSel = isr;
        else
            readSel = irr;
    end

    always_ff @(posedge clk) begin
        if (resetIRR) begin
            intr        <= 1'b0;
            vectorValid <= 1'b0;
            readValid   <= 1'b0;
        end else begin
            intr        <= pendingValid;   // One cycle behind pending
            vectorValid <= ackEvent.strobe;
            readValid   <= rd;
        end
    end

    // Payload registers, qualified by their valid strobes
    always_ff @(posedge clk) begin
        if (ackEvent.strobe)
            vector <= {cfg.vectorBase, ackEvent.level}; // Base | level
        if (rd)
            readData <= readSel;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/picPkg.sv
logic/commandDecoder.sv
logic/interruptRequestRegister.sv
logic/priorityResolver.sv
logic/vectorOutput.sv
logic/interruptController.sv
verif/tbInterruptController.sv

//--- verif/tbInterruptController.sv
//####################
// Directed testbench for the interrupt controller
// Drives host writes, IR lines and inta and checks against a bench model
//####################
`default_nettype none

`include "pic_defines.svh"

module tbInterruptController;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 16;  // Longest response delay allowed
    localparam int TEST_BUDGET  = 200; // Worst-case cycles of one test
    localparam int TEST_COUNT   = 6;
    localparam int MARGIN       = 100;

    logic                  clk;
    logic                  resetIRR;
    picPkg::hostWrite_t    hostWr;
    logic [`PIC_LINES-1:0] requestLines;
    logic                  inta;
    logic                  rd;
    logic                  readA0;
    logic                  intr;
    logic                  vectorValid;
    logic [7:0]            vector;
    logic                  readValid;
    logic [`PIC_LINES-1:0] readData;

    // Bench model of the controller state
    logic [`PIC_LINES-1:0]    modelIrr;
    logic [`PIC_LINES-1:0]    modelIsr;
    logic [`PIC_LINES-1:0]    modelMask;
    logic [7:`PIC_LEVEL_BITS] modelBase;
    logic                     modelLevelMode;

    integer seed = 32'h9608;
    int     errorCount;
    int     checkCount;
    int     timeoutCount;

    interruptController UUT (
        .clk(clk), .resetIRR(resetIRR), .hostWr(hostWr), .requestLines(requestLines),
        .inta(inta), .rd(rd), .readA0(readA0), .intr(intr), .vectorValid(vectorValid),
        .vector(vector), .readValid(readValid), .readData(readData)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic checkVector(input string testName, input logic [7:0] expected,
                               input logic [7:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %s: vector expected %02h, actual %02h", testName, expected, actual);
        end
    endtask

    task automatic checkReadData(input string testName,
                                 input logic [`PIC_LINES-1:0] expected,
                                 input logic [`PIC_LINES-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %s: readData expected %02h, actual %02h",
                     testName, expected, actual);
        end
    endtask

    task automatic checkIntr(input string testName, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %s: intr expected %b, actual %b", testName, expected, actual);
        end
    endtask

    task automatic checkStrobe(input string testName, input string strobeName,
                               input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %s: %s expected %b, actual %b",
                     testName, strobeName, expected, actual);
        end
    endtask

    // Highest irr level not blocked by an in-service level or -1 if none
    function automatic int modelPending();
        for (int i = 0; i < `PIC_LINES; i++) begin
            if (modelIsr[i])
                return -1;          // Blocks itself and all lower levels
            if (modelIrr[i])
                return i;
        end
        return -1;
    endfunction

    task automatic writeCommand(input logic a0, input logic [7:0] data);
        @(posedge clk);
        hostWr <= '{wr: 1'b1, a0: a0, data: data};
        @(posedge clk);
        hostWr <= '0;
    endtask

    task automatic writeIcw1(input logic levelMode);
        writeCommand(1'b0, {3'b000, 1'b1, levelMode, 3'b000});
        modelLevelMode = levelMode;
        modelMask      = '0;        // ICW1 clears the IMR
    endtask

    task automatic writeIcw2(input logic [7:0] base);
        writeCommand(1'b1, base);
        modelBase = base[7:`PIC_LEVEL_BITS];
    endtask

    task automatic setMask(input logic [`PIC_LINES-1:0] mask);
        writeCommand(1'b1, mask);   // OCW1
        modelMask = mask;
        modelIrr  = modelIrr & ~mask; // Stored bits drop out too
    endtask

    // One-cycle pulse that edge mode captures unless masked
    task automatic pulseLines(input logic [`PIC_LINES-1:0] lines);
        @(posedge clk);
        requestLines <= requestLines | lines;
        @(posedge clk);
        requestLines <= requestLines & ~lines;
        if (!modelLevelMode)
            modelIrr = modelIrr | (lines & ~modelMask);
    endtask

    task automatic driveLines(input logic [`PIC_LINES-1:0] value);
        @(posedge clk);
        requestLines <= value;
    endtask

    task automatic waitIntr(input string testName, input logic expected);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (intr !== expected && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        checkIntr(testName, expected, intr);
    endtask

    task automatic holdIntrLow(input string testName, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checkIntr(testName, 1'b0, intr);
        end
    endtask

    task automatic readRegister(input string testName, input logic a0,
                                input logic [`PIC_LINES-1:0] expected);
        int cycles;
        cycles = 0;
        @(posedge clk);
        rd     <= 1'b1;
        readA0 <= a0;
        @(posedge clk);
        rd <= 1'b0;
        @(negedge clk);
        while (!readValid && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!readValid) begin
            timeoutCount++;
            $display("%s: readValid never arrived after rd", testName);
        end else begin
            checkReadData(testName, expected, readData);
            @(negedge clk);
            checkStrobe(testName, "readValid", 1'b0, readValid); // Single-cycle strobe
        end
    endtask

    task automatic readIrr(input string testName);
        writeCommand(1'b0, 8'h0A);  // OCW3 with RR set and RIS clear
        readRegister(testName, 1'b0, modelIrr);
    endtask

    task automatic readIsr(input string testName);
        writeCommand(1'b0, 8'h0B);  // OCW3 with RR and RIS set
        readRegister(testName, 1'b0, modelIsr);
    endtask

    // inta pulse checked against the model vector with level 7 when spurious
    task automatic acknowledge(input string testName);
        int         level;
        int         cycles;
        logic [7:0] expected;
        level  = modelPending();
        cycles = 0;
        if (level < 0)
            expected = {modelBase, `PIC_LEVEL_BITS'(`PIC_SPURIOUS_LEVEL)};
        else
            expected = {modelBase, `PIC_LEVEL_BITS'(level)};
        @(posedge clk);
        inta <= 1'b1;
        @(posedge clk);
        inta <= 1'b0;
        @(negedge clk);
        while (!vectorValid && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!vectorValid) begin
            timeoutCount++;
            $display("%s: vectorValid never arrived after inta", testName);
        end else begin
            checkVector(testName, expected, vector);
            @(negedge clk);
            checkStrobe(testName, "vectorValid", 1'b0, vectorValid); // Single-cycle strobe
        end
        if (level >= 0) begin
            modelIsr = modelIsr | (`PIC_LINES'(1) << level);
            if (!modelLevelMode)
                modelIrr = modelIrr & ~(`PIC_LINES'(1) << level); // Edge consumed
        end
    endtask

    task automatic endOfInterrupt(input logic specific, input int level);
        int top;
        top = -1;
        if (specific) begin
            writeCommand(1'b0, {3'b011, 2'b00, `PIC_LEVEL_BITS'(level)});
            modelIsr = modelIsr & ~(`PIC_LINES'(1) << level);
        end else begin
            writeCommand(1'b0, 8'h20);  // OCW2 non-specific
            for (int i = 0; i < `PIC_LINES; i++)
                if (modelIsr[i] && top < 0)
                    top = i;
            if (top >= 0)
                modelIsr = modelIsr & ~(`PIC_LINES'(1) << top);
        end
        @(posedge clk);                 // isr clears one edge after the event
    endtask

    task automatic testInitAndMask();
        logic [31:0] randomWord;
        string       name;
        name = "init and mask";
        writeIcw1(1'b0);
        pulseLines(8'h02);              // IR1 captured while init is not done
        holdIntrLow(name, 6);
        writeIcw2(8'h40);
        waitIntr(name, 1'b1);
        acknowledge(name);
        endOfInterrupt(1'b0, 0);
        randomWord = $random(seed);
        setMask(randomWord[7:0]);
        readRegister(name, 1'b1, modelMask);
        setMask('0);
        readRegister(name, 1'b1, modelMask);
        waitIntr(name, 1'b0);
    endtask

    task automatic testEdgeAck();
        string name;
        name = "edge capture";
        pulseLines(8'h08);
        waitIntr(name, 1'b1);
        acknowledge(name);              // Base | 3
        readIsr(name);
        readIrr(name);
        endOfInterrupt(1'b0, 0);
        readIsr(name);
    endtask

    task automatic testPriorityNesting();
        string name;
        name = "priority nesting";
        pulseLines(8'h24);              // IR5 and IR2 together
        waitIntr(name, 1'b1);
        acknowledge(name);              // IR2 wins
        waitIntr(name, 1'b0);
        holdIntrLow(name, 8);           // IR5 blocked by IR2 in service
        endOfInterrupt(1'b0, 0);
        waitIntr(name, 1'b1);
        acknowledge(name);
        endOfInterrupt(1'b0, 0);
        waitIntr(name, 1'b0);
    endtask

    task automatic testMasking();
        string name;
        name = "masking";
        setMask(8'h50);
        pulseLines(8'h10);              // Masked IR4 pulse
        driveLines(8'h40);              // IR6 held while masked
        holdIntrLow(name, 6);
        readIrr(name);
        setMask('0);
        holdIntrLow(name, 6);           // Held line gives no new edge
        readIrr(name);
        driveLines(8'h00);
        driveLines(8'h40);
        modelIrr = modelIrr | 8'h40;
        waitIntr(name, 1'b1);
        acknowledge(name);
        endOfInterrupt(1'b0, 0);
        driveLines(8'h00);
        waitIntr(name, 1'b0);
    endtask

    task automatic testLevelMode();
        string name;
        name = "level mode";
        writeIcw1(1'b1);
        writeIcw2(8'h40);
        driveLines(8'h40);
        modelIrr = 8'h40;               // Follows the held line
        waitIntr(name, 1'b1);
        readIrr(name);
        acknowledge(name);
        waitIntr(name, 1'b0);
        readIrr(name);                  // Bit 6 back after the ack dip
        endOfInterrupt(1'b0, 0);
        waitIntr(name, 1'b1);
        driveLines(8'h00);
        modelIrr = '0;
        waitIntr(name, 1'b0);
        readIrr(name);
    endtask

    task automatic testSpuriousEoi();
        string name;
        name = "spurious and specific EOI";
        writeIcw1(1'b0);
        writeIcw2(8'hA8);
        pulseLines(8'h10);
        waitIntr(name, 1'b1);
        acknowledge(name);
        waitIntr(name, 1'b0);
        acknowledge(name);              // Nothing pending
        readIsr(name);
        pulseLines(8'h02);              // IR1 nests above IR4
        waitIntr(name, 1'b1);
        acknowledge(name);
        endOfInterrupt(1'b1, 4);
        readIsr(name);
        endOfInterrupt(1'b0, 0);
        readIsr(name);
    endtask

    // Watchdog budget covers reset and every test at its worst case
    initial begin
        #((RESET_CYCLES + TEST_COUNT * TEST_BUDGET + MARGIN) * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        errorCount     = 0;
        checkCount     = 0;
        timeoutCount   = 0;
        modelIrr       = '0;
        modelIsr       = '0;
        modelMask      = '0;
        modelBase      = '0;
        modelLevelMode = 1'b0;
        resetIRR     <= 1'b1;
        hostWr       <= '0;
        requestLines <= '0;
        inta         <= 1'b0;
        rd           <= 1'b0;
        readA0       <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetIRR <= 1'b0;

        testInitAndMask();
        testEdgeAck();
        testPriorityNesting();
        testMasking();
        testLevelMode();
        testSpuriousEoi();

        repeat (4) @(posedge clk);
        $display("Checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
